// File: common/rate_pkg.sv
// token width must stay wider than the 16-bit length field so a full bucket can hold any packet
package rate_pkg;

    // byte credit counter width
    // 20 bits covers depths up to about one megabyte
    // which is far beyond the largest legal packet length
    localparam int TOKEN_WIDTH = 20;

    // per-cycle credit increment
    // 8 bits means at most 255 bytes of credit per clock
    localparam int RATE_WIDTH = 8;

    // default input buffer depth in beats
    // back-pressure reaches s_tready once this many beats are queued
    localparam int FIFO_DEPTH_DEFAULT = 16;

endpackage

// File: common/stream_pkg.sv
// the low 16 bits of tuser carry the packet length in bytes and widths assume whole bytes per beat
package stream_pkg;

    // default beat payload width in bits
    // must be a multiple of 8 so that every strobe bit covers one byte
    localparam int DATA_WIDTH = 64;

    // one strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // metadata word travelling with every beat
    // only the first beat's copy matters to the limiter
    localparam int USER_WIDTH = 128;

    // packet length field inside the metadata
    // byte count of the whole packet, not of the beat
    localparam int LEN_LSB = 0;

    // 16 bits gives packets up to 65535 bytes
    localparam int LEN_WIDTH = 16;

endpackage

// File: hw/stream_fifo.sv
// first-word-fall-through FIFO with no bypass so a written word reaches the head one cycle later
module stream_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,

    // write side
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,

    // read side, head shown before it is taken
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    // pointer and occupancy widths
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 wr_en;
    logic                 rd_en;
    logic [PTR_WIDTH-1:0] wr_ptr_next;
    logic [PTR_WIDTH-1:0] rd_ptr_next;

    // full only at DEPTH entries
    assign in_ready  = (count != CNT_WIDTH'(DEPTH));
    assign out_valid = (count != '0);

    // head word straight from storage
    assign out_data  = mem[rd_ptr];

    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    // explicit wrap so DEPTH need not be a power of two
    assign wr_ptr_next = (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_next = (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    // storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr_next;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr_next;
            end
            // simultaneous read and write leaves count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rate_limiter/packet_gate.sv
// the length in the first beat's tuser decides the charge and later beats are never inspected
module packet_gate #(
    parameter int DATA_WIDTH  = stream_pkg::DATA_WIDTH,
    parameter int USER_WIDTH  = stream_pkg::USER_WIDTH,
    parameter int TOKEN_WIDTH = rate_pkg::TOKEN_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset,

    // head of the input FIFO
    input  logic [DATA_WIDTH-1:0]   head_tdata,
    input  logic [DATA_WIDTH/8-1:0] head_tstrb,
    input  logic [USER_WIDTH-1:0]   head_tuser,
    input  logic                    head_tlast,
    input  logic                    head_valid,
    output logic                    head_ready,

    // credit from the bucket
    input  logic [TOKEN_WIDTH-1:0]  tokens,
    input  logic [TOKEN_WIDTH-1:0]  bucket_depth,

    // output stream
    output logic [DATA_WIDTH-1:0]   m_tdata,
    output logic [DATA_WIDTH/8-1:0] m_tstrb,
    output logic [USER_WIDTH-1:0]   m_tuser,
    output logic                    m_tlast,
    output logic                    m_tvalid,
    input  logic                    m_tready,

    // debit request to the bucket
    output logic                    charge,
    output logic [TOKEN_WIDTH-1:0]  charge_len
);

    localparam int LEN_PAD = TOKEN_WIDTH - stream_pkg::LEN_WIDTH;

    typedef enum logic {
        ST_START,
        ST_PACKET
    } gate_state_t;

    gate_state_t                    state;
    logic [stream_pkg::LEN_WIDTH-1:0] pkt_len;
    logic [TOKEN_WIDTH-1:0]         need;
    logic                           credit_ok;
    logic                           open;
    logic                           beat_moves;

    // length field of the head beat
    assign pkt_len = head_tuser[stream_pkg::LEN_LSB +: stream_pkg::LEN_WIDTH];

    // oversize packets only need a full bucket
    always_comb begin
        need = {{LEN_PAD{1'b0}}, pkt_len};
        if (need > bucket_depth) begin
            need = bucket_depth;
        end
    end

    assign credit_ok = (tokens >= need);

    // mid-packet the gate is always open
    assign open = (state == ST_PACKET) | credit_ok;

    // beat fields pass untouched
    assign m_tdata = head_tdata;
    assign m_tstrb = head_tstrb;
    assign m_tuser = head_tuser;
    assign m_tlast = head_tlast;

    // valid never looks at ready
    assign m_tvalid   = head_valid & open;
    // FIFO pops only when the beat really leaves
    assign head_ready = m_tready & open;
    assign beat_moves = m_tvalid & m_tready;

    // charge once, on the cycle the first beat moves
    // stalled first beats keep waiting without a debit
    assign charge     = (state == ST_START) & beat_moves;
    assign charge_len = need;

    // two-state packet tracker
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_START;
        end else begin
            case (state)
                ST_START: begin
                    // single-beat packets stay here
                    if (beat_moves && !head_tlast) begin
                        state <= ST_PACKET;
                    end
                end
                ST_PACKET: begin
                    if (beat_moves && head_tlast) begin
                        state <= ST_START;
                    end
                end
                default: state <= ST_START;
            endcase
        end
    end

endmodule

// File: rate_limiter/rate_limiter_top.sv
// rate and depth are plain inputs read every cycle and bucket_depth must not be zero at reset
module rate_limiter_top #(
    parameter int DATA_WIDTH  = stream_pkg::DATA_WIDTH,
    parameter int USER_WIDTH  = stream_pkg::USER_WIDTH,
    parameter int FIFO_DEPTH  = rate_pkg::FIFO_DEPTH_DEFAULT,
    parameter int TOKEN_WIDTH = rate_pkg::TOKEN_WIDTH,
    parameter int RATE_WIDTH  = rate_pkg::RATE_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset,

    // limiter configuration
    input  logic [RATE_WIDTH-1:0]   rate_inc,
    input  logic [TOKEN_WIDTH-1:0]  bucket_depth,

    // input stream
    input  logic [DATA_WIDTH-1:0]   s_tdata,
    input  logic [DATA_WIDTH/8-1:0] s_tstrb,
    input  logic [USER_WIDTH-1:0]   s_tuser,
    input  logic                    s_tlast,
    input  logic                    s_tvalid,
    output logic                    s_tready,

    // output stream
    output logic [DATA_WIDTH-1:0]   m_tdata,
    output logic [DATA_WIDTH/8-1:0] m_tstrb,
    output logic [USER_WIDTH-1:0]   m_tuser,
    output logic                    m_tlast,
    output logic                    m_tvalid,
    input  logic                    m_tready
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    // packed beat layout, msb first: data, strobe, user, last
    localparam int BEAT_WIDTH = DATA_WIDTH + STRB_WIDTH + USER_WIDTH + 1;

    logic [BEAT_WIDTH-1:0]  in_beat;
    logic [BEAT_WIDTH-1:0]  head_beat;
    logic                   head_valid;
    logic                   head_ready;
    logic [TOKEN_WIDTH-1:0] tokens;
    logic                   charge;
    logic [TOKEN_WIDTH-1:0] charge_len;

    assign in_beat = {s_tdata, s_tstrb, s_tuser, s_tlast};

    // input buffer, holds several packets while one passes the gate
    stream_fifo #(
        .WIDTH (BEAT_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_beat),
        .in_valid  (s_tvalid),
        .in_ready  (s_tready),
        .out_data  (head_beat),
        .out_valid (head_valid),
        .out_ready (head_ready)
    );

    // byte credit
    token_bucket #(
        .TOKEN_WIDTH (TOKEN_WIDTH),
        .RATE_WIDTH  (RATE_WIDTH)
    ) bucket_i (
        .clk          (clk),
        .reset        (reset),
        .rate_inc     (rate_inc),
        .bucket_depth (bucket_depth),
        .charge       (charge),
        .charge_len   (charge_len),
        .tokens       (tokens)
    );

    // head word split back into fields on the way in
    packet_gate #(
        .DATA_WIDTH  (DATA_WIDTH),
        .USER_WIDTH  (USER_WIDTH),
        .TOKEN_WIDTH (TOKEN_WIDTH)
    ) gate_i (
        .clk          (clk),
        .reset        (reset),
        .head_tdata   (head_beat[BEAT_WIDTH-1 -: DATA_WIDTH]),
        .head_tstrb   (head_beat[USER_WIDTH+1 +: STRB_WIDTH]),
        .head_tuser   (head_beat[1 +: USER_WIDTH]),
        .head_tlast   (head_beat[0]),
        .head_valid   (head_valid),
        .head_ready   (head_ready),
        .tokens       (tokens),
        .bucket_depth (bucket_depth),
        .m_tdata      (m_tdata),
        .m_tstrb      (m_tstrb),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .charge       (charge),
        .charge_len   (charge_len)
    );

endmodule

// File: rate_limiter/token_bucket.sv
// caller must never charge more than the current tokens since the counter has no underflow guard
module token_bucket #(
    parameter int TOKEN_WIDTH = rate_pkg::TOKEN_WIDTH,
    parameter int RATE_WIDTH  = rate_pkg::RATE_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,

    // configuration, sampled every cycle
    input  logic [RATE_WIDTH-1:0]  rate_inc,
    input  logic [TOKEN_WIDTH-1:0] bucket_depth,

    // debit for a packet that starts this cycle
    input  logic                   charge,
    input  logic [TOKEN_WIDTH-1:0] charge_len,

    // current byte credit
    output logic [TOKEN_WIDTH-1:0] tokens
);

    // one spare bit so tokens plus increment cannot wrap
    logic [TOKEN_WIDTH:0] with_inc;
    logic [TOKEN_WIDTH:0] after_charge;
    logic [TOKEN_WIDTH:0] depth_ext;
    logic [TOKEN_WIDTH:0] debit;

    assign depth_ext = {1'b0, bucket_depth};

    // debit is zero unless a packet starts
    assign debit = charge ? {1'b0, charge_len} : '0;

    // increment and charge land in the same update
    always_comb begin
        with_inc     = {1'b0, tokens} + {{(TOKEN_WIDTH + 1 - RATE_WIDTH){1'b0}}, rate_inc};
        // gate guarantees debit <= tokens, so no borrow here
        after_charge = with_inc - debit;
    end

    // credit register
    always_ff @(posedge clk) begin
        if (reset) begin
            // bucket starts full
            tokens <= bucket_depth;
        end else if (after_charge > depth_ext) begin
            // cap at depth
            // also pulls tokens down if depth is lowered at run time
            tokens <= bucket_depth;
        end else begin
            tokens <= after_charge[TOKEN_WIDTH-1:0];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rate_limiter_tb -f verilog.f

status=0
./obj_dir/Vrate_limiter_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
# an assertion abort ends the run without the pass line
if [ "$status" -ne 0 ] || ! grep -q "Testbench passed" sim.log; then
    exit 1
fi
exit 0

// File: test/rate_limiter_sva.sv
// bound to rate_limiter_top at default widths and reads its internal charge strobe
module rate_limiter_sva #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH,
    parameter int USER_WIDTH = stream_pkg::USER_WIDTH
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    s_tready,
    input logic [DATA_WIDTH-1:0]   m_tdata,
    input logic [DATA_WIDTH/8-1:0] m_tstrb,
    input logic [USER_WIDTH-1:0]   m_tuser,
    input logic                    m_tlast,
    input logic                    m_tvalid,
    input logic                    m_tready,
    input logic                    charge
);

    // high between a packet's first and last beat
    logic in_pkt;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (m_tvalid && m_tready) begin
            in_pkt <= !m_tlast;
        end
    end

    // stalled beat holds until taken
    assert property (@(posedge clk) disable iff (reset)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tstrb)
            && $stable(m_tuser) && $stable(m_tlast)))
        else $error("output beat changed while stalled");

    // debit exactly when a first beat leaves
    assert property (@(posedge clk) disable iff (reset)
        charge == (m_tvalid && m_tready && !in_pkt))
        else $error("charge not aligned with a moving first beat");

    // empty FIFO accepts right after reset
    assert property (@(posedge clk) reset |=> s_tready)
        else $error("s_tready low after reset");

endmodule

bind rate_limiter_top rate_limiter_sva sva_i (
    .clk (clk), .reset (reset), .s_tready (s_tready),
    .m_tdata (m_tdata), .m_tstrb (m_tstrb), .m_tuser (m_tuser), .m_tlast (m_tlast),
    .m_tvalid (m_tvalid), .m_tready (m_tready), .charge (charge)
);

// File: test/rate_limiter_tb.sv
// runs the limiter at its package default widths and expects the length field in tuser bits 15:0
module rate_limiter_tb;

    localparam int DW = stream_pkg::DATA_WIDTH;
    localparam int SW = stream_pkg::STRB_WIDTH;
    localparam int UW = stream_pkg::USER_WIDTH;
    localparam int TW = rate_pkg::TOKEN_WIDTH;
    localparam int FIFO_DEPTH = rate_pkg::FIFO_DEPTH_DEFAULT;

    logic                            clk = 1'b0;
    logic                            reset;
    logic [rate_pkg::RATE_WIDTH-1:0] rate_inc;
    logic [TW-1:0]                   bucket_depth;
    logic [DW-1:0]                   s_tdata;
    logic [SW-1:0]                   s_tstrb;
    logic [UW-1:0]                   s_tuser;
    logic                            s_tlast;
    logic                            s_tvalid;
    logic                            s_tready;
    logic [DW-1:0]                   m_tdata;
    logic [SW-1:0]                   m_tstrb;
    logic [UW-1:0]                   m_tuser;
    logic                            m_tlast;
    logic                            m_tvalid;
    logic                            m_tready = 1'b0;

    // expected beats in FIFO order
    logic [DW-1:0] exp_data[$];
    logic [SW-1:0] exp_strb[$];
    logic [UW-1:0] exp_user[$];
    logic          exp_last[$];

    // expected fields of the beat leaving this cycle
    logic [UW-1:0] head_user;
    logic          head_last;

    // shadow of the bucket and packet bookkeeping
    int          model_tokens;
    int          debit;
    int          cycle_count;
    int          pkts_started;
    int          len_sum;
    logic        in_pkt;
    logic        bound_check = 1'b0;
    int          stall_pct = 0;
    logic        hold_ready_low = 1'b1;
    logic [31:0] stim_rng = 32'd9863;
    logic [31:0] ready_rng = 32'd9863;

    rate_limiter_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk (clk), .reset (reset), .rate_inc (rate_inc), .bucket_depth (bucket_depth),
        .s_tdata (s_tdata), .s_tstrb (s_tstrb), .s_tuser (s_tuser), .s_tlast (s_tlast),
        .s_tvalid (s_tvalid), .s_tready (s_tready),
        .m_tdata (m_tdata), .m_tstrb (m_tstrb), .m_tuser (m_tuser), .m_tlast (m_tlast),
        .m_tvalid (m_tvalid), .m_tready (m_tready)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // low LCG bits have short periods so only upper bits are used
    function automatic int rnd_below(input int n);
        stim_rng = lcg_step(stim_rng);
        return int'(stim_rng[30:16]) % n;
    endfunction

    function automatic logic [31:0] rnd32();
        logic [15:0] hi;
        stim_rng = lcg_step(stim_rng);
        hi = stim_rng[31:16];
        stim_rng = lcg_step(stim_rng);
        return {hi, stim_rng[31:16]};
    endfunction

    // credit a first beat needs with oversize clamped to a full bucket
    function automatic int credit_need(input logic [UW-1:0] user);
        int len;
        len = int'(user[stream_pkg::LEN_LSB +: stream_pkg::LEN_WIDTH]);
        return (len > int'(bucket_depth)) ? int'(bucket_depth) : len;
    endfunction

    task automatic end_in_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input logic [DW-1:0] got, input logic [DW-1:0] exp);
        if (got !== exp) end_in_failure($sformatf("FAIL m_tdata got %h expected %h", got, exp));
    endtask

    task automatic check_strb(input logic [SW-1:0] got, input logic [SW-1:0] exp);
        if (got !== exp) end_in_failure($sformatf("FAIL m_tstrb got %h expected %h", got, exp));
    endtask

    task automatic check_user(input logic [UW-1:0] got, input logic [UW-1:0] exp);
        if (got !== exp) end_in_failure($sformatf("FAIL m_tuser got %h expected %h", got, exp));
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) end_in_failure($sformatf("FAIL m_tlast got %h expected %h", got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) end_in_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // random output stalls or ready held low for back-pressure
    always @(negedge clk) begin
        ready_rng = lcg_step(ready_rng);
        m_tready = !hold_ready_low && (int'(ready_rng[23:16]) % 100 >= stall_pct);
    end

    // reference model and output checks
    always @(posedge clk) begin
        if (reset) begin
            exp_data.delete();
            exp_strb.delete();
            exp_user.delete();
            exp_last.delete();
            model_tokens = int'(bucket_depth);
            cycle_count = 0;
            pkts_started = 0;
            len_sum = 0;
            in_pkt = 1'b0;
        end else begin
            debit = 0;
            // a first beat with enough credit must be offered
            if (!in_pkt && exp_user.size() != 0 && !m_tvalid &&
                model_tokens >= credit_need(exp_user[0]))
                end_in_failure("first beat held back although the credit was enough");
            // no holes inside a packet while beats wait in the FIFO
            if (in_pkt && !m_tvalid && exp_user.size() != 0)
                end_in_failure("m_tvalid dropped inside a packet with beats waiting");
            if (m_tvalid && m_tready) begin
                if (exp_user.size() == 0) end_in_failure("output beat with no matching input beat");
                head_user = exp_user[0];
                head_last = exp_last[0];
                check_data(m_tdata, exp_data.pop_front());
                check_strb(m_tstrb, exp_strb.pop_front());
                check_user(m_tuser, exp_user.pop_front());
                check_last(m_tlast, exp_last.pop_front());
                if (!in_pkt) begin
                    debit = credit_need(head_user);
                    if (model_tokens < debit)
                        end_in_failure("packet started before the credit allowed it");
                    pkts_started++;
                    len_sum += int'(head_user[stream_pkg::LEN_LSB +: stream_pkg::LEN_WIDTH]);
                    if (bound_check && len_sum > int'(bucket_depth) + int'(rate_inc) * cycle_count)
                        end_in_failure("started bytes exceed depth plus rate times cycles");
                end
                in_pkt = !head_last;
            end
            if (s_tvalid && s_tready) begin
                exp_data.push_back(s_tdata);
                exp_strb.push_back(s_tstrb);
                exp_user.push_back(s_tuser);
                exp_last.push_back(s_tlast);
            end
            // earn and pay then saturate at depth
            model_tokens = model_tokens + int'(rate_inc) - debit;
            if (model_tokens > int'(bucket_depth)) model_tokens = int'(bucket_depth);
            cycle_count++;
        end
    end

    task automatic apply_reset(input int rate, input int depth);
        @(negedge clk);
        reset = 1'b1;
        s_tvalid = 1'b0;
        rate_inc = rate[rate_pkg::RATE_WIDTH-1:0];
        bucket_depth = TW'(depth);
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    // holds the beat until a rising edge takes it
    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!s_tready) begin
            if (waited == 2000) end_in_failure("input beat was never accepted");
            waited++;
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic send_packet(input int len, input int gap_pct);
        int beats;
        int rem;
        beats = (len + SW - 1) / SW;
        for (int b = 0; b < beats; b++) begin
            if (rnd_below(100) < gap_pct) begin
                s_tvalid = 1'b0;
                repeat (1 + rnd_below(4)) @(negedge clk);
            end
            rem = len - b * SW;
            s_tdata = DW'({rnd32(), rnd32()});
            // partial strobe on a short last beat
            s_tstrb = (rem >= SW) ? '1 : SW'((1 << rem) - 1);
            s_tuser = UW'({rnd32(), rnd32(), rnd32(), rnd32()});
            s_tuser[stream_pkg::LEN_LSB +: stream_pkg::LEN_WIDTH] = stream_pkg::LEN_WIDTH'(len);
            s_tlast = (b == beats - 1);
            s_tvalid = 1'b1;
            wait_accept();
        end
        s_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_last.size() != 0 || in_pkt) begin
            if (waited == 20000) end_in_failure("output did not drain in time");
            waited++;
            @(negedge clk);
        end
    endtask

    initial begin
        int lens[$];
        int sum;
        int waited;
        int accepted;
        reset = 1'b1;
        rate_inc = '0;
        bucket_depth = '0;
        s_tdata = '0;
        s_tstrb = '0;
        s_tuser = '0;
        s_tlast = 1'b0;
        s_tvalid = 1'b0;

        // order, credit bound and atomicity under random gaps and stalls
        apply_reset(4, 512);
        bound_check = 1'b1;
        stall_pct = 30;
        hold_ready_low = 1'b0;
        for (int p = 0; p < 24; p++) begin
            send_packet(1 + rnd_below(300), 20);
        end
        wait_drain();
        bound_check = 1'b0;

        // no refill so only the prefix that fits in 1000 bytes may start
        apply_reset(0, 1000);
        stall_pct = 0;
        sum = 0;
        while (sum <= 1000) begin
            lens.push_back(1 + rnd_below(128));
            sum += lens[lens.size() - 1];
        end
        foreach (lens[i]) begin
            send_packet(lens[i], 0);
        end
        waited = 0;
        while (pkts_started != lens.size() - 1 || in_pkt) begin
            if (waited == 5000) end_in_failure("packets within the budget did not all start");
            waited++;
            @(negedge clk);
        end
        repeat (200) begin
            @(negedge clk);
            if (m_tvalid) end_in_failure("m_tvalid rose with an exhausted bucket");
        end
        check_count("packets started", pkts_started, lens.size() - 1);

        // oversize packet then followers that must wait for refill
        apply_reset(2, 128);
        stall_pct = 25;
        send_packet(300, 10);
        for (int p = 0; p < 4; p++) begin
            send_packet(1 + rnd_below(300), 10);
        end
        wait_drain();

        // output blocked so the FIFO fills from empty
        hold_ready_low = 1'b1;
        apply_reset(4, 512);
        accepted = 0;
        waited = 0;
        s_tdata = DW'({rnd32(), rnd32()});
        s_tstrb = '1;
        s_tuser = UW'(300);
        s_tlast = 1'b0;
        s_tvalid = 1'b1;
        while (s_tready) begin
            if (waited == 100) end_in_failure("s_tready never fell under back-pressure");
            waited++;
            accepted++;
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        check_count("accepted beats", accepted, FIFO_DEPTH);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog.f
common/stream_pkg.sv
common/rate_pkg.sv
hw/stream_fifo.sv
rate_limiter/token_bucket.sv
rate_limiter/packet_gate.sv
rate_limiter/rate_limiter_top.sv
test/rate_limiter_sva.sv
test/rate_limiter_tb.sv
